// ==== rtl/udp_echo_pkg.sv ====
/*
 * UDP echo shared types and configuration constants
 */
`default_nettype none

package udp_echo_pkg;

    // Payload stream geometry
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // Payload FIFO depth in beats (power of two)
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // Destination port that gets echoed
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    // Own address 192.168.1.128
    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Reply TTL, applied by the outer IP stack
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // UDP header as seen on both rx and tx sides
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        // Ignored on input, zero on output
        logic [15:0] checksum;
    } udp_hdr_t;

    // One beat of the payload stream
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        logic                  user;
    } axis_beat_t;

endpackage

`default_nettype wire

// ==== rtl/echo_frame_ctrl.sv ====
/*
 * Echo frame controller: matches the UDP port, builds the reply header
 * and steers each payload into the FIFO or drops it
 */
`timescale 1ns/1ps
`default_nettype none

module echo_frame_ctrl
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  udp_hdr_t   rx_hdr,
    input  logic       rx_hdr_valid,
    output logic       rx_hdr_ready,

    output udp_hdr_t   tx_hdr,
    output logic       tx_hdr_valid,
    input  logic       tx_hdr_ready,

    input  axis_beat_t rx_pay,
    input  logic       rx_pay_valid,
    output logic       rx_pay_ready,

    output axis_beat_t fifo_in,
    output logic       fifo_in_valid,
    input  logic       fifo_in_ready
);

    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DROP
    } state_t;

    state_t state;
    state_t state_next;

    logic port_match;
    logic hdr_fire;
    logic pay_fire;

    assign port_match = (rx_hdr.dst_port == ECHO_PORT);

    // Reply header is a pure remap of the received one
    always_comb begin
        tx_hdr.src_ip   = LOCAL_IP;
        tx_hdr.dst_ip   = rx_hdr.src_ip;
        tx_hdr.src_port = rx_hdr.dst_port;
        tx_hdr.dst_port = rx_hdr.src_port;
        tx_hdr.length   = rx_hdr.length;
        tx_hdr.checksum = 16'd0;
    end

    // Beats go to the FIFO untouched
    assign fifo_in = rx_pay;

    // Handshake steering per state
    always_comb begin
        rx_hdr_ready  = 1'b0;
        tx_hdr_valid  = 1'b0;
        rx_pay_ready  = 1'b0;
        fifo_in_valid = 1'b0;

        case (state)
            IDLE: begin
                // Only a matching header waits on the reply side
                tx_hdr_valid = rx_hdr_valid && port_match;
                rx_hdr_ready = port_match ? tx_hdr_ready : 1'b1;
            end
            FORWARD: begin
                rx_pay_ready  = fifo_in_ready;
                fifo_in_valid = rx_pay_valid;
            end
            DROP: begin
                // Swallow beats silently
                rx_pay_ready = 1'b1;
            end
            default: begin
                rx_pay_ready = 1'b0;
            end
        endcase
    end

    assign hdr_fire = rx_hdr_valid && rx_hdr_ready;
    assign pay_fire = rx_pay_valid && rx_pay_ready;

    always_comb begin
        state_next = state;

        case (state)
            IDLE: begin
                if (hdr_fire) begin
                    state_next = port_match ? FORWARD : DROP;
                end
            end
            FORWARD, DROP: begin
                // Frame ends on the transfer of its last beat
                if (pay_fire && rx_pay.last) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/payload_fifo.sv ====
/*
 * Synchronous payload FIFO with occupancy count and valid/ready on both ports
 */
`timescale 1ns/1ps
`default_nettype none

module payload_fifo
    import udp_echo_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH
)
(
    input  logic       clk,
    input  logic       rst,

    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,

    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W + 1)'(DEPTH);

    // Storage, no reset needed on payload
    axis_beat_t mem [0:DEPTH-1];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;

    logic wr_en;
    logic rd_en;

    assign in_ready  = (count != FULL_COUNT);
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // Simultaneous push and pop keeps the level
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/first_byte_led.sv ====
/*
 * Status capture: low byte of the first beat of each outgoing frame
 */
`timescale 1ns/1ps
`default_nettype none

module first_byte_led
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  axis_beat_t beat,
    input  logic       valid,
    input  logic       ready,

    output logic [7:0] led
);

    logic in_frame;
    logic xfer;

    assign xfer = valid && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= 8'd0;
        end else if (xfer) begin
            // First transfer after a last beat opens a new frame
            if (!in_frame) begin
                led <= beat.data[7:0];
            end
            in_frame <= !beat.last;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/udp_echo_core.sv ====
/*
 * UDP echo core: replies to frames on the echo port with swapped
 * addressing and buffered payload, drops all others
 */
`timescale 1ns/1ps
`default_nettype none

module udp_echo_core
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Received UDP frame
    input  udp_hdr_t   rx_hdr,
    input  logic       rx_hdr_valid,
    output logic       rx_hdr_ready,
    input  axis_beat_t rx_pay,
    input  logic       rx_pay_valid,
    output logic       rx_pay_ready,

    // Reply UDP frame
    output udp_hdr_t   tx_hdr,
    output logic       tx_hdr_valid,
    input  logic       tx_hdr_ready,
    output axis_beat_t tx_pay,
    output logic       tx_pay_valid,
    input  logic       tx_pay_ready,

    output logic [7:0] led
);

    // Controller to FIFO
    axis_beat_t fifo_in;
    logic       fifo_in_valid;
    logic       fifo_in_ready;

    echo_frame_ctrl i_echo_frame_ctrl (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr        (rx_hdr),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .tx_hdr        (tx_hdr),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .rx_pay        (rx_pay),
        .rx_pay_valid  (rx_pay_valid),
        .rx_pay_ready  (rx_pay_ready),
        .fifo_in       (fifo_in),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready)
    );

    // FIFO output is the reply payload stream
    payload_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fifo_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_beat  (tx_pay),
        .out_valid (tx_pay_valid),
        .out_ready (tx_pay_ready)
    );

    // Watches the outgoing payload only
    first_byte_led i_first_byte_led (
        .clk   (clk),
        .rst   (rst),
        .beat  (tx_pay),
        .valid (tx_pay_valid),
        .ready (tx_pay_ready),
        .led   (led)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_udp_echo_core.sv ====
/*
 * Directed testbench for the UDP echo core with a reply model and
 * stream monitors on the tx header and payload
 */
`timescale 1ns/1ps
`default_nettype none

module tb_udp_echo_core
    import udp_echo_pkg::*;
();

    logic       clk;
    logic       rst;
    udp_hdr_t   rx_hdr;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    axis_beat_t rx_pay;
    logic       rx_pay_valid;
    logic       rx_pay_ready;
    udp_hdr_t   tx_hdr;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready;
    axis_beat_t tx_pay;
    logic       tx_pay_valid;
    logic       tx_pay_ready;
    logic [7:0] led;

    integer     seed;
    int         errors;
    int         timeouts;
    int         hdr_xfers;
    int         pay_xfers;
    int         rx_stalls;
    udp_hdr_t   exp_hdr_q[$];
    axis_beat_t exp_beat_q[$];
    udp_hdr_t   exp_h;
    axis_beat_t exp_b;
    logic [7:0] exp_led;
    logic       toggle_readies;
    logic [2:0] rdy_draw;
    logic       pay_stalled;
    axis_beat_t stalled_beat;

    udp_echo_core i_udp_echo_core (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_pay       (rx_pay),
        .rx_pay_valid (rx_pay_valid),
        .rx_pay_ready (rx_pay_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_pay       (tx_pay),
        .tx_pay_valid (tx_pay_valid),
        .tx_pay_ready (tx_pay_ready),
        .led          (led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ready pattern drawn on the rising edge, applied on the falling edge
    always @(posedge clk) begin
        if (toggle_readies) begin
            rdy_draw = 3'($random(seed));
        end
    end

    // Payload ready is high a quarter of the time so the FIFO fills
    always @(negedge clk) begin
        if (toggle_readies) begin
            tx_hdr_ready = rdy_draw[0];
            tx_pay_ready = rdy_draw[1] && rdy_draw[2];
        end else begin
            tx_hdr_ready = 1'b1;
            tx_pay_ready = 1'b1;
        end
    end

    // Reply header as defined by the echo rules
    function automatic udp_hdr_t reply_of(input udp_hdr_t h);
        udp_hdr_t r;
        r.src_ip   = LOCAL_IP;
        r.dst_ip   = h.src_ip;
        r.src_port = h.dst_port;
        r.dst_port = h.src_port;
        r.length   = h.length;
        r.checksum = 16'd0;
        return r;
    endfunction

    // Monitor for tx transfers and stall behavior
    always @(posedge clk) begin
        if (rst) begin
            pay_stalled = 1'b0;
        end else begin
            if (rx_hdr_valid && rx_hdr_ready && rx_hdr.dst_port == ECHO_PORT
                    && !tx_hdr_ready) begin
                errors++;
                $display("error at %0t: matching header accepted while tx_hdr_ready low", $time);
            end
            if (pay_stalled && (!tx_pay_valid || tx_pay !== stalled_beat)) begin
                errors++;
                $display("error at %0t: tx_pay beat changed while stalled", $time);
            end
            // Input stall during a frame means the FIFO is full
            if (rx_pay_valid && !rx_pay_ready) begin
                rx_stalls++;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                hdr_xfers++;
                if (exp_hdr_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: unexpected reply header %h", $time, tx_hdr);
                end else begin
                    exp_h = exp_hdr_q.pop_front();
                    if (tx_hdr !== exp_h) begin
                        errors++;
                        $display("error at %0t: reply header %h, expected %h",
                                 $time, tx_hdr, exp_h);
                    end
                end
            end
            if (tx_pay_valid && tx_pay_ready) begin
                pay_xfers++;
                if (exp_beat_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: unexpected payload beat %h", $time, tx_pay);
                end else begin
                    exp_b = exp_beat_q.pop_front();
                    if (tx_pay !== exp_b) begin
                        errors++;
                        $display("error at %0t: payload beat %h, expected %h",
                                 $time, tx_pay, exp_b);
                    end
                end
            end
            pay_stalled  = tx_pay_valid && !tx_pay_ready;
            stalled_beat = tx_pay;
        end
    end

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic drive_hdr(input udp_hdr_t h);
        int waited;
        waited       = 0;
        rx_hdr       = h;
        rx_hdr_valid = 1'b1;
        @(posedge clk);
        while (!rx_hdr_ready && waited < 200) begin
            waited++;
            @(posedge clk);
        end
        if (!rx_hdr_ready) begin
            timeouts++;
            $display("timeout: rx header was never accepted");
        end
        @(negedge clk);
        rx_hdr_valid = 1'b0;
    endtask

    task automatic drive_beat(input axis_beat_t b);
        int waited;
        waited       = 0;
        rx_pay       = b;
        rx_pay_valid = 1'b1;
        @(posedge clk);
        while (!rx_pay_ready && waited < 200) begin
            waited++;
            @(posedge clk);
        end
        if (!rx_pay_ready) begin
            timeouts++;
            $display("timeout: rx payload beat was never accepted");
        end
        @(negedge clk);
        rx_pay_valid = 1'b0;
    endtask

    // Builds one frame, queues the expected reply and drives it
    task automatic send_frame(input logic [31:0] src_ip, input logic [15:0] dst_port,
                              input int nbeats, input int user_idx,
                              input logic [7:0] last_keep);
        udp_hdr_t   h;
        axis_beat_t beats[$];
        axis_beat_t b;
        int         n_bytes;
        for (int i = 0; i < nbeats; i++) begin
            b.data = {$random(seed), $random(seed)};
            b.keep = (i == nbeats - 1) ? last_keep : 8'hff;
            b.last = (i == nbeats - 1);
            b.user = (i == user_idx);
            beats.push_back(b);
        end
        n_bytes    = (nbeats - 1) * 8 + $countones(last_keep);
        h.src_ip   = src_ip;
        // Random destination that the reply must not copy
        h.dst_ip   = $random(seed);
        h.src_port = 16'd5000 + 16'(nbeats);
        h.dst_port = dst_port;
        h.length   = 16'(8 + n_bytes);
        // Garbage checksum, must not reach the reply
        h.checksum = 16'($random(seed));
        if (dst_port == ECHO_PORT) begin
            exp_hdr_q.push_back(reply_of(h));
            foreach (beats[i]) begin
                exp_beat_q.push_back(beats[i]);
            end
            exp_led = beats[0].data[7:0];
        end
        drive_hdr(h);
        foreach (beats[i]) begin
            drive_beat(beats[i]);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) && waited < 500) begin
            waited++;
            @(negedge clk);
        end
        if (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            timeouts++;
            $display("timeout: reply still missing %0d headers and %0d beats",
                     exp_hdr_q.size(), exp_beat_q.size());
        end
    endtask

    task automatic test_reset();
        compare_value("tx_hdr_valid after reset", 64'(tx_hdr_valid), 64'd0);
        compare_value("tx_pay_valid after reset", 64'(tx_pay_valid), 64'd0);
        compare_value("rx_pay_ready after reset", 64'(rx_pay_ready), 64'd0);
        compare_value("led after reset", 64'(led), 64'd0);
    endtask

    task automatic test_echo();
        int h0;
        int p0;
        h0 = hdr_xfers;
        p0 = pay_xfers;
        send_frame(32'hc0a8_010a, ECHO_PORT, 3, 1, 8'h1f);
        wait_drain();
        compare_value("echo header count", 64'(hdr_xfers - h0), 64'd1);
        compare_value("echo beat count", 64'(pay_xfers - p0), 64'd3);
    endtask

    task automatic test_drop();
        int h0;
        int p0;
        h0 = hdr_xfers;
        p0 = pay_xfers;
        send_frame(32'hc0a8_0114, 16'd4321, 4, -1, 8'hff);
        repeat (50) @(negedge clk);
        compare_value("drop header count", 64'(hdr_xfers - h0), 64'd0);
        compare_value("drop beat count", 64'(pay_xfers - p0), 64'd0);
    endtask

    task automatic test_backpressure();
        int h0;
        int p0;
        int s0;
        h0 = hdr_xfers;
        p0 = pay_xfers;
        s0 = rx_stalls;
        toggle_readies = 1'b1;
        send_frame(32'h0a00_0005, ECHO_PORT, 2 * FIFO_DEPTH + 8, 5, 8'h03);
        wait_drain();
        toggle_readies = 1'b0;
        compare_value("stalled header count", 64'(hdr_xfers - h0), 64'd1);
        compare_value("stalled beat count", 64'(pay_xfers - p0), 64'(2 * FIFO_DEPTH + 8));
        if (rx_stalls == s0) begin
            errors++;
            $display("error at %0t: rx payload never stalled on a full FIFO", $time);
        end
    endtask

    task automatic test_status();
        send_frame(32'hc0a8_0133, ECHO_PORT, 2, 0, 8'hff);
        wait_drain();
        compare_value("led after echo", 64'(led), 64'(exp_led));
        send_frame(32'hc0a8_0134, 16'd80, 2, -1, 8'h0f);
        repeat (50) @(negedge clk);
        compare_value("led after drop", 64'(led), 64'(exp_led));
    endtask

    task automatic test_mixed();
        int h0;
        int p0;
        h0 = hdr_xfers;
        p0 = pay_xfers;
        send_frame(32'hac10_0001, ECHO_PORT, 2, 1, 8'h01);
        send_frame(32'hac10_0002, 16'd1235, 3, 0, 8'hff);
        send_frame(32'hac10_0003, ECHO_PORT, 1, 0, 8'h7f);
        send_frame(32'hac10_0004, ECHO_PORT, 4, 2, 8'h3f);
        wait_drain();
        compare_value("mixed header count", 64'(hdr_xfers - h0), 64'd3);
        compare_value("mixed beat count", 64'(pay_xfers - p0), 64'd7);
        compare_value("led after mixed", 64'(led), 64'(exp_led));
    endtask

    initial begin
        seed           = 32'h7538_7b13;
        errors         = 0;
        timeouts       = 0;
        hdr_xfers      = 0;
        pay_xfers      = 0;
        rx_stalls      = 0;
        exp_led        = 8'd0;
        toggle_readies = 1'b0;
        rdy_draw       = 3'b111;
        pay_stalled    = 1'b0;
        rst            = 1'b1;
        rx_hdr         = '0;
        rx_hdr_valid   = 1'b0;
        rx_pay         = '0;
        rx_pay_valid   = 1'b0;
        tx_hdr_ready   = 1'b1;
        tx_pay_ready   = 1'b1;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        test_reset();
        test_echo();
        test_drop();
        test_backpressure();
        test_status();
        test_mixed();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/udp_echo_pkg.sv
rtl/echo_frame_ctrl.sv
rtl/payload_fifo.sv
rtl/first_byte_led.sv
rtl/udp_echo_core.sv
testbench/tb_udp_echo_core.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_udp_echo_core
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
